/* branch_predictor.f */
+incdir+test
src/bpu_pkg.sv
src/bpu_update_if.sv
src/branch_history_table.sv
src/pattern_history_table.sv
src/branch_target_buffer.sv
src/branch_predictor.sv
test/branch_predictor_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the branch predictor testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module branch_predictor_tb -f branch_predictor.f -o branch_predictor_sim

output=$(./obj_dir/branch_predictor_sim)
echo "$output"

if grep -qx "sim passed" <<< "$output"; then
    exit 0
fi
exit 1

/* src/bpu_pkg.sv */
`default_nettype none

package bpu_pkg;

    ////////////////////////////////////////
    // default widths
    ////////////////////////////////////////

    // pc and target width
    localparam int PC_WIDTH = 32;
    // pc bits above bit 2 indexing bht and pht
    localparam int INDEX_BITS = 8;
    // local history length, kept equal to INDEX_BITS
    localparam int HIST_BITS = 8;
    // pc bits above bit 2 indexing the btb
    localparam int BTB_INDEX_BITS = 6;

    ////////////////////////////////////////
    // 2-bit saturating counter
    ////////////////////////////////////////

    // upper bit is the taken prediction
    typedef enum logic [1:0] {
        strong_not_taken = 2'd0,
        weak_not_taken   = 2'd1,
        weak_taken       = 2'd2,
        strong_taken     = 2'd3
    } ctr_state_t;

    // one step toward taken, sticks at the top
    function automatic ctr_state_t ctr_inc(input ctr_state_t s);
        case (s)
            strong_not_taken: return weak_not_taken;
            weak_not_taken:   return weak_taken;
            default:          return strong_taken;
        endcase
    endfunction

    // one step toward not taken, sticks at the bottom
    function automatic ctr_state_t ctr_dec(input ctr_state_t s);
        case (s)
            strong_taken: return weak_taken;
            weak_taken:   return weak_not_taken;
            default:      return strong_not_taken;
        endcase
    endfunction

endpackage

`default_nettype wire

/* src/bpu_update_if.sv */
`timescale 1ns/10ps
`default_nettype none

// training bundle from dispatch/execute
interface bpu_update_if
    import bpu_pkg::*;
();

    // one retired branch per high cycle
    logic                update_en;
    // pc of the branch being trained
    logic [PC_WIDTH-1:0] pc;
    // resolved direction
    logic                taken;
    // resolved target, only meaningful when taken
    logic [PC_WIDTH-1:0] target;

    // driver side
    modport source (
        output update_en,
        output pc,
        output taken,
        output target
    );

    // table side
    modport sink (
        input update_en,
        input pc,
        input taken,
        input target
    );

endinterface

`default_nettype wire

/* src/branch_history_table.sv */
`timescale 1ns/10ps
`default_nettype none

// per-branch local history, one shift register per pc index
module branch_history_table
    import bpu_pkg::*;
#(
    parameter int INDEX_BITS = bpu_pkg::INDEX_BITS,
    parameter int HIST_BITS  = bpu_pkg::HIST_BITS
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic [PC_WIDTH-1:0]  fetch_pc,
    bpu_update_if.sink                upd,
    output logic      [HIST_BITS-1:0] fetch_history,
    output logic      [HIST_BITS-1:0] update_history
);

    localparam int ENTRIES = 1 << INDEX_BITS;

    ////////////////////////////////////////
    // index and storage
    ////////////////////////////////////////

    // word-aligned pc, skip bits 1:0
    logic [INDEX_BITS-1:0] fetch_idx;
    logic [INDEX_BITS-1:0] upd_idx;

    // history registers, newest outcome at bit 0
    logic [HIST_BITS-1:0] hist_mem [ENTRIES];

    assign fetch_idx = fetch_pc[INDEX_BITS+1:2];
    assign upd_idx   = upd.pc[INDEX_BITS+1:2];

    ////////////////////////////////////////
    // read ports
    ////////////////////////////////////////

    // fetch side, same cycle as pc
    assign fetch_history  = hist_mem[fetch_idx];
    // update side sees the old entry, feeds pht training
    assign update_history = hist_mem[upd_idx];

    ////////////////////////////////////////
    // shift in resolved outcome
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            // all histories back to zero
            hist_mem <= '{default: '0};
        end else if (upd.update_en) begin
            // oldest bit falls off the top
            hist_mem[upd_idx] <= {update_history[HIST_BITS-2:0], upd.taken};
        end
    end

endmodule

`default_nettype wire

/* src/branch_predictor.sv */
`timescale 1ns/10ps
`default_nettype none

// fetch-stage branch predictor, local two-level direction plus btb target
module branch_predictor
    import bpu_pkg::*;
#(
    parameter int INDEX_BITS     = bpu_pkg::INDEX_BITS,
    parameter int HIST_BITS      = bpu_pkg::HIST_BITS,
    parameter int BTB_INDEX_BITS = bpu_pkg::BTB_INDEX_BITS
) (
    input  wire logic                clk,
    input  wire logic                rst,

    // fetch lookup
    input  wire logic [PC_WIDTH-1:0] fetch_pc,

    // training from dispatch/execute
    input  wire logic                update_en,
    input  wire logic [PC_WIDTH-1:0] update_pc,
    input  wire logic                update_taken,
    input  wire logic [PC_WIDTH-1:0] update_target,

    // prediction, combinational from fetch_pc
    output logic                     predict_taken,
    output logic                     predict_hit,
    output logic      [PC_WIDTH-1:0] predict_target
);

    ////////////////////////////////////////
    // internal wiring
    ////////////////////////////////////////

    // training bundle shared by all three tables
    bpu_update_if upd ();

    // bht to pht
    logic [HIST_BITS-1:0] fetch_history;
    logic [HIST_BITS-1:0] update_history;

    // direction from pht
    logic pht_taken;

    assign upd.update_en = update_en;
    assign upd.pc        = update_pc;
    assign upd.taken     = update_taken;
    assign upd.target    = update_target;

    ////////////////////////////////////////
    // tables
    ////////////////////////////////////////

    branch_history_table #(
        .INDEX_BITS (INDEX_BITS),
        .HIST_BITS  (HIST_BITS)
    ) u_bht (
        .clk            (clk),
        .rst            (rst),
        .fetch_pc       (fetch_pc),
        .upd            (upd.sink),
        .fetch_history  (fetch_history),
        .update_history (update_history)
    );

    pattern_history_table #(
        .INDEX_BITS (INDEX_BITS),
        .HIST_BITS  (HIST_BITS)
    ) u_pht (
        .clk            (clk),
        .rst            (rst),
        .fetch_pc       (fetch_pc),
        .fetch_history  (fetch_history),
        .update_history (update_history),
        .upd            (upd.sink),
        .taken          (pht_taken)
    );

    branch_target_buffer #(
        .BTB_INDEX_BITS (BTB_INDEX_BITS)
    ) u_btb (
        .clk    (clk),
        .rst    (rst),
        .fetch_pc (fetch_pc),
        .upd    (upd.sink),
        .hit    (predict_hit),
        .target (predict_target)
    );

    // no target known means no taken redirect
    assign predict_taken = pht_taken & predict_hit;

endmodule

`default_nettype wire

/* src/branch_target_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

// direct-mapped btb, tells fetch whether pc is a known branch and where it goes
module branch_target_buffer
    import bpu_pkg::*;
#(
    parameter int BTB_INDEX_BITS = bpu_pkg::BTB_INDEX_BITS
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic [PC_WIDTH-1:0] fetch_pc,
    bpu_update_if.sink               upd,
    output logic                     hit,
    output logic      [PC_WIDTH-1:0] target
);

    localparam int ENTRIES  = 1 << BTB_INDEX_BITS;
    // everything above the index is tag
    localparam int TAG_BITS = PC_WIDTH - BTB_INDEX_BITS - 2;

    ////////////////////////////////////////
    // entry storage
    ////////////////////////////////////////

    logic                valid_mem  [ENTRIES];
    logic [TAG_BITS-1:0] tag_mem    [ENTRIES];
    logic [PC_WIDTH-1:0] target_mem [ENTRIES];

    ////////////////////////////////////////
    // address split
    ////////////////////////////////////////

    // fetch side
    logic [BTB_INDEX_BITS-1:0] fetch_idx;
    logic [TAG_BITS-1:0]       fetch_tag;

    // update side
    logic [BTB_INDEX_BITS-1:0] upd_idx;
    logic [TAG_BITS-1:0]       upd_tag;

    // allocate only on resolved-taken branches
    logic alloc;

    assign fetch_idx = fetch_pc[BTB_INDEX_BITS+1:2];
    assign fetch_tag = fetch_pc[PC_WIDTH-1:BTB_INDEX_BITS+2];

    assign upd_idx = upd.pc[BTB_INDEX_BITS+1:2];
    assign upd_tag = upd.pc[PC_WIDTH-1:BTB_INDEX_BITS+2];

    assign alloc = upd.update_en & upd.taken;

    ////////////////////////////////////////
    // lookup
    ////////////////////////////////////////

    // hit needs a live entry and a full tag match
    assign hit    = valid_mem[fetch_idx] && (tag_mem[fetch_idx] == fetch_tag);
    // target passed straight out, qualified by hit at the top
    assign target = target_mem[fetch_idx];

    ////////////////////////////////////////
    // valid bits
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_mem <= '{default: 1'b0};
        end else if (alloc) begin
            valid_mem[upd_idx] <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // tag and target payload
    ////////////////////////////////////////

    // aliasing entry simply gets replaced
    always_ff @(posedge clk) begin
        if (alloc) begin
            tag_mem[upd_idx]    <= upd_tag;
            target_mem[upd_idx] <= upd.target;
        end
    end

    // not-taken updates leave the entry alone, so a
    // branch that stops being taken keeps its target

endmodule

`default_nettype wire

/* src/pattern_history_table.sv */
`timescale 1ns/10ps
`default_nettype none

// 2-bit counters, indexed by local history xor pc index
module pattern_history_table
    import bpu_pkg::*;
#(
    parameter int INDEX_BITS = bpu_pkg::INDEX_BITS,
    parameter int HIST_BITS  = bpu_pkg::HIST_BITS
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic [PC_WIDTH-1:0]  fetch_pc,
    input  wire logic [HIST_BITS-1:0] fetch_history,
    input  wire logic [HIST_BITS-1:0] update_history,
    bpu_update_if.sink                upd,
    output logic                      taken
);

    // one counter per history value
    localparam int ENTRIES = 1 << HIST_BITS;

    ////////////////////////////////////////
    // index forming
    ////////////////////////////////////////

    // pc slices, same bits the bht uses
    logic [INDEX_BITS-1:0] fetch_pc_idx;
    logic [INDEX_BITS-1:0] upd_pc_idx;

    // hashed table indices
    logic [HIST_BITS-1:0] fetch_idx;
    logic [HIST_BITS-1:0] upd_idx;

    // counter storage
    ctr_state_t ctr_mem [ENTRIES];

    // counter read for the prediction
    ctr_state_t fetch_ctr;
    // counter under training
    ctr_state_t upd_ctr;

    assign fetch_pc_idx = fetch_pc[INDEX_BITS+1:2];
    assign upd_pc_idx   = upd.pc[INDEX_BITS+1:2];

    // xor mixes pc and history, widths equal by design
    assign fetch_idx = fetch_history ^ fetch_pc_idx;
    // update index from the history before this update shifts it
    assign upd_idx   = update_history ^ upd_pc_idx;

    ////////////////////////////////////////
    // prediction
    ////////////////////////////////////////

    assign fetch_ctr = ctr_mem[fetch_idx];

    // weak_taken and strong_taken both have bit 1 set
    assign taken = fetch_ctr[1];

    ////////////////////////////////////////
    // training
    ////////////////////////////////////////

    assign upd_ctr = ctr_mem[upd_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            // everything starts biased not taken
            ctr_mem <= '{default: strong_not_taken};
        end else if (upd.update_en) begin
            if (upd.taken) begin
                ctr_mem[upd_idx] <= ctr_inc(upd_ctr);
            end else begin
                ctr_mem[upd_idx] <= ctr_dec(upd_ctr);
            end
        end
    end

endmodule

`default_nettype wire

/* test/bpu_model.svh */
`ifndef BPU_MODEL_SVH
`define BPU_MODEL_SVH

// golden copy of the predictor state at default widths
localparam int M_IDX = 8;
localparam int M_BTB = 6;

logic [M_IDX-1:0] m_hist   [1 << M_IDX];
logic [1:0]       m_ctr    [1 << M_IDX];
logic             m_valid  [1 << M_BTB];
logic [23:0]      m_tag    [1 << M_BTB];
logic [31:0]      m_target [1 << M_BTB];

// histories zero, counters strongly not taken, btb empty
function automatic void model_reset();
    for (int i = 0; i < (1 << M_IDX); i++) begin
        m_hist[i] = '0;
        m_ctr[i]  = 2'd0;
    end
    for (int i = 0; i < (1 << M_BTB); i++) begin
        m_valid[i] = 1'b0;
    end
endfunction

// counter slot, local history xor pc bits 9:2
function automatic logic [M_IDX-1:0] ctr_slot(input logic [31:0] pc);
    return m_hist[pc[M_IDX+1:2]] ^ pc[M_IDX+1:2];
endfunction

function automatic void model_predict(input logic [31:0] pc, output logic taken,
                                      output logic hit, output logic [31:0] target);
    hit    = m_valid[pc[M_BTB+1:2]] && (m_tag[pc[M_BTB+1:2]] == pc[31:M_BTB+2]);
    // taken needs a known target too
    taken  = m_ctr[ctr_slot(pc)][1] && hit;
    target = m_target[pc[M_BTB+1:2]];
endfunction

// old history picks the counter, then the history shifts
function automatic void model_update(input logic [31:0] pc, input logic t,
                                     input logic [31:0] target);
    logic [M_IDX-1:0] s;
    s = ctr_slot(pc);
    if (t && m_ctr[s] != 2'd3) begin
        m_ctr[s] = m_ctr[s] + 2'd1;
    end else if (!t && m_ctr[s] != 2'd0) begin
        m_ctr[s] = m_ctr[s] - 2'd1;
    end
    m_hist[pc[M_IDX+1:2]] = {m_hist[pc[M_IDX+1:2]][M_IDX-2:0], t};
    // only taken outcomes allocate
    if (t) begin
        m_valid[pc[M_BTB+1:2]]  = 1'b1;
        m_tag[pc[M_BTB+1:2]]    = pc[31:M_BTB+2];
        m_target[pc[M_BTB+1:2]] = target;
    end
endfunction

`endif

/* test/branch_predictor_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_predictor_tb;

    localparam int CLK_PERIOD  = 40;
    localparam int SAT_LIMIT   = 40;
    localparam int RAND_CYCLES = 300;
    // reset, reset state, saturation bound, pattern, btb, random, mid-run reset
    localparam int PLANNED_CYCLES = 4 + 20 + 2 * SAT_LIMIT + 56 + 10 + RAND_CYCLES + 26;

    logic        clk;
    logic        rst;
    logic        update_en;
    logic        update_taken;
    logic [31:0] fetch_pc;
    logic [31:0] update_pc;
    logic [31:0] update_target;
    logic        predict_taken;
    logic        predict_hit;
    logic [31:0] predict_target;

    int          check_count;
    int          fail_count;
    int          test_fails;
    logic [31:0] lfsr_state;

    `include "bpu_model.svh"

    branch_predictor dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // random bits
    ////////////////////////////////////////

    // galois lfsr with taps 32 22 2 1
    function automatic logic next_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    // small pool so branches repeat
    // bit 8 gives btb aliases
    function automatic logic [31:0] pool_pc();
        return 32'h0000_4000 | (rand_bits(1) << 8) | (rand_bits(5) << 2);
    endfunction

    ////////////////////////////////////////
    // checks and stimulus
    ////////////////////////////////////////

    task automatic expect_bits(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got == exp) else begin
            fail_count++;
            $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // dut vs model at each falling edge and then the model trains
    always @(negedge clk) begin
        logic        e_taken;
        logic        e_hit;
        logic [31:0] e_target;
        if (rst) begin
            model_reset();
        end else begin
            model_predict(fetch_pc, e_taken, e_hit, e_target);
            expect_bits("predict_hit", {31'd0, predict_hit}, {31'd0, e_hit});
            expect_bits("predict_taken", {31'd0, predict_taken}, {31'd0, e_taken});
            if (e_hit) begin
                expect_bits("predict_target", predict_target, e_target);
            end
            if (update_en) begin
                model_update(update_pc, update_taken, update_target);
            end
        end
    end

    // one strobe with fetch on the same pc
    task automatic train(input logic [31:0] pc, input logic t, input logic [31:0] target);
        @(posedge clk);
        update_en     <= 1'b1;
        update_pc     <= pc;
        update_taken  <= t;
        update_target <= target;
        fetch_pc      <= pc;
    endtask

    // lookup only and back once outputs have settled
    task automatic look(input logic [31:0] pc);
        @(posedge clk);
        update_en <= 1'b0;
        fetch_pc  <= pc;
        @(negedge clk);
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d checks failed", name, fail_count - test_fails);
        test_fails = fail_count;
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        logic [31:0] pc;
        int          trips;
        check_count = 0;
        fail_count  = 0;
        test_fails  = 0;
        lfsr_state  = 32'ha0947456;
        rst           <= 1'b1;
        update_en     <= 1'b0;
        update_taken  <= 1'b0;
        update_pc     <= '0;
        update_target <= '0;
        fetch_pc      <= '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // nothing known after reset
        repeat (20) begin
            look(rand_bits(30) << 2);
            expect_bits("reset hit,taken", {30'd0, predict_hit, predict_taken}, 32'd0);
        end
        end_test("reset state");

        // always taken until history is all ones and its counter saturated
        pc = 32'h0000_2468;
        trips = 0;
        do begin
            train(pc, 1'b1, 32'h0000_8000);
            look(pc);
            trips++;
        end while ((m_hist[pc[9:2]] != 8'hff || m_ctr[ctr_slot(pc)] != 2'd3)
                   && trips < SAT_LIMIT);
        expect_bits("saturated predict_taken", {31'd0, predict_taken}, 32'd1);
        expect_bits("saturated predict_target", predict_target, 32'h0000_8000);
        end_test("always taken");

        // alternating outcomes where each history value owns its counter
        pc = 32'h0000_3a0c;
        for (int i = 0; i < 48; i++) begin
            train(pc, i[0], 32'h0000_9000);
        end
        for (int i = 0; i < 4; i++) begin
            train(pc, i[0], 32'h0000_9000);
            look(pc);
            expect_bits("pattern predict_taken", {31'd0, predict_taken}, {31'd0, ~i[0]});
        end
        end_test("local pattern");

        // 0x1040, 0x1140, 0x1240 share btb index 0x10
        train(32'h0000_1040, 1'b1, 32'h0000_2000);
        look(32'h0000_1040);
        expect_bits("first alloc predict_hit", {31'd0, predict_hit}, 32'd1);
        train(32'h0000_1140, 1'b1, 32'h0000_3000);
        look(32'h0000_1040);
        expect_bits("evicted predict_hit", {31'd0, predict_hit}, 32'd0);
        train(32'h0000_1240, 1'b0, 32'h0000_4000);
        look(32'h0000_1240);
        expect_bits("not-taken predict_hit", {31'd0, predict_hit}, 32'd0);
        look(32'h0000_1140);
        expect_bits("surviving predict_target", predict_target, 32'h0000_3000);
        end_test("btb tags");

        // random strobes with fetch often on the pc being trained
        repeat (RAND_CYCLES) begin
            pc = pool_pc();
            @(posedge clk);
            update_en     <= next_bit();
            update_pc     <= pc;
            update_taken  <= next_bit();
            update_target <= rand_bits(30) << 2;
            fetch_pc      <= (rand_bits(2) == 32'd0) ? pc : pool_pc();
        end
        end_test("random traffic");

        // reset on trained tables
        @(posedge clk);
        rst       <= 1'b1;
        update_en <= 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (20) begin
            look(pool_pc());
            expect_bits("post-reset hit,taken", {30'd0, predict_hit, predict_taken}, 32'd0);
        end
        end_test("mid-run reset");

        $display("%0d checks, %0d passed, %0d failed",
                 check_count, check_count - fail_count, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // twice the planned cycle count
    initial begin
        #(PLANNED_CYCLES * CLK_PERIOD * 2);
        $display("timeout, run did not finish within %0d cycles", 2 * PLANNED_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
